//--- Makefile
# Verilator build and run of the JTAG TAP testbench.

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module jtag_tap_tb \
		-Mdir obj_dir -o jtag_tap_sim

# The run fails unless the log holds the pass line.
run: compile
	./obj_dir/jtag_tap_sim > sim.log 2>&1; cat sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- build.f
+incdir+hdl
hdl/jtag_tap_state_pkg.sv
hdl/jtag_tap_instr_pkg.sv
hdl/jtag_tap_fsm.sv
hdl/jtag_instr_reg.sv
hdl/jtag_data_regs.sv
hdl/jtag_tap_top.sv
dv/jtag_tap_clk_gen.sv
dv/jtag_tap_tb.sv

//--- dv/jtag_tap_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module jtag_tap_clk_gen
(
   output logic jtag_tck_o,
   output logic jtag_trstn_o
);

   // TRST starts low so the DUT comes up in reset.
   logic trstn_q = 1'b0;

   assign jtag_trstn_o = trstn_q;

   // Free running TCK with a 20 ns period.
   initial
   begin
      jtag_tck_o = 1'b0;
      forever
      begin
         #10 jtag_tck_o = ~jtag_tck_o;
      end
   end

   // TRST goes low on a falling edge and stays low for three TCK cycles.
   // It is released on a falling edge too, away from the rising edge that moves the FSM.
   task automatic apply_reset();
      @(negedge jtag_tck_o);
      trstn_q <= 1'b0;
      repeat (3) @(posedge jtag_tck_o);
      @(negedge jtag_tck_o);
      trstn_q <= 1'b1;
   endtask

   initial
   begin
      apply_reset();
   end

endmodule

`default_nettype wire

//--- dv/jtag_tap_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "jtag_tap_macros.svh"

module jtag_tap_tb
   import jtag_tap_state_pkg::*;
   import jtag_tap_instr_pkg::*;
();

   // TDO is sampled 1 ns before the rising edge, half a period after the falling edge.
   localparam int SAMPLE_DELAY = 9;
   // The scans below take roughly 320 TCK cycles, so 2000 leaves a wide margin.
   localparam int CYCLE_LIMIT = 2000;

   logic   jtag_tck;
   logic   jtag_trstn;
   logic   jtag_tms;
   logic   jtag_tdi;
   logic   debug_tdo;
   logic   jtag_tdo;
   logic   tlr_flag;
   logic   capture_dr_flag;
   logic   shift_dr_flag;
   logic   update_dr_flag;
   logic   debug_sel;
   integer seed;
   int     errors = 0;
   int     cycles = 0;

   jtag_tap_clk_gen clk0 (
      .jtag_tck_o   (jtag_tck),
      .jtag_trstn_o (jtag_trstn)
   );

   jtag_tap_top dut0 (
      .jtag_tck_i                         (jtag_tck),
      .jtag_trstn_i                       (jtag_trstn),
      .jtag_tms_i                         (jtag_tms),
      .jtag_tdi_i                         (jtag_tdi),
      .debug_tdo_i                        (debug_tdo),
      .jtag_tdo_o                         (jtag_tdo),
      .is_tap_state_test_logic_reset_o    (tlr_flag),
      .is_tap_state_capture_dr_o          (capture_dr_flag),
      .is_tap_state_shift_dr_o            (shift_dr_flag),
      .is_tap_state_update_dr_o           (update_dr_flag),
      .is_tap_current_instruction_debug_o (debug_sel)
   );

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         errors++;
         $display("Error: %s expected %b actual %b", name, exp, act);
      end
   endtask

   task automatic check_instr(input string name, input jtag_instr_e exp, input jtag_instr_e act);
      if (act !== exp)
      begin
         errors++;
         $display("Error: %s expected %b actual %b", name, exp, act);
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp)
      begin
         errors++;
         $display("Error: %s expected %h actual %h", name, exp, act);
      end
   endtask

   // One TCK cycle. Inputs change on the falling edge, TDO is read just before the rising one.
   // Nonblocking drives keep the DUT's falling-edge TDO flop on the old debug_tdo_i value.
   task automatic tms_step(input logic tms, input logic tdi, input logic dbg, output logic tdo);
      @(negedge jtag_tck);
      jtag_tms  <= tms;
      jtag_tdi  <= tdi;
      debug_tdo <= dbg;
      #(SAMPLE_DELAY);
      tdo = jtag_tdo;
   endtask

   // Starts and ends in Run-Test/Idle and returns the bits shifted out of the IR.
   task automatic load_ir(input jtag_instr_e code, output logic [`JTAG_IR_LEN-1:0] captured);
      logic tdo;
      // Select-DR-Scan, Select-IR-Scan, Capture-IR, then Shift-IR.
      tms_step(1'b1, 1'b0, 1'b0, tdo);
      tms_step(1'b1, 1'b0, 1'b0, tdo);
      tms_step(1'b0, 1'b0, 1'b0, tdo);
      tms_step(1'b0, 1'b0, 1'b0, tdo);
      for (int i = 0; i < `JTAG_IR_LEN; i++)
      begin
         tms_step(i == `JTAG_IR_LEN - 1, code[i], 1'b0, tdo);
         captured[i] = tdo;
      end
      // Exit1-IR, Update-IR, and one idle cycle so the new instruction is visible.
      tms_step(1'b1, 1'b0, 1'b0, tdo);
      tms_step(1'b0, 1'b0, 1'b0, tdo);
      tms_step(1'b0, 1'b0, 1'b0, tdo);
   endtask

   // Shifts n bits through the selected DR, starting and ending in Run-Test/Idle.
   task automatic scan_dr(input int n, input logic [63:0] din, output logic [63:0] dout);
      logic tdo;
      dout = '0;
      tms_step(1'b1, 1'b0, 1'b0, tdo);
      tms_step(1'b0, 1'b0, 1'b0, tdo);
      tms_step(1'b0, 1'b0, 1'b0, tdo);
      for (int i = 0; i < n; i++)
      begin
         tms_step(i == n - 1, din[i], 1'b0, tdo);
         dout[i] = tdo;
      end
      tms_step(1'b1, 1'b0, 1'b0, tdo);
      tms_step(1'b0, 1'b0, 1'b0, tdo);
   endtask

   // A cycle with random TDI and debug input; exp holds capture, shift and update flags.
   task automatic dr_flag_step(input string name, input logic tms, input logic [2:0] exp,
                               output logic tdo, output logic dbg);
      dbg = 1'($random(seed));
      tms_step(tms, 1'($random(seed)), dbg, tdo);
      check_bit({name, " capture flag"}, exp[2], capture_dr_flag);
      check_bit({name, " shift flag"}, exp[1], shift_dr_flag);
      check_bit({name, " update flag"}, exp[0], update_dr_flag);
   endtask

   // IDCODE is the reset instruction, so a DR scan returns the identifier LSB first.
   task automatic test_reset_idcode();
      logic        tdo;
      logic [63:0] dout;
      tms_step(1'b0, 1'b0, 1'b0, tdo);
      check_bit("reset tlr flag", 1'b1, tlr_flag);
      scan_dr(32, {$random(seed), $random(seed)}, dout);
      check_word("reset idcode", `JTAG_IDCODE_VALUE, dout[31:0]);
   endtask

   task automatic test_ir_capture_tms_reset();
      logic                    tdo;
      logic [`JTAG_IR_LEN-1:0] captured;
      logic [`JTAG_IR_LEN-1:0] exp_capture;
      logic [63:0]             dout;
      exp_capture = {`JTAG_IR_CAPTURE_STATUS, `JTAG_IR_CAPTURE_MARKER};
      load_ir(instr_bypass, captured);
      for (int i = 0; i < `JTAG_IR_LEN; i++)
      begin
         check_bit("ir capture word", exp_capture[i], captured[i]);
      end
      check_instr("ir bypass loaded", instr_bypass, dut0.cur_instr);
      // Walk into Shift-DR, then five TMS-high cycles must end in Test-Logic-Reset.
      tms_step(1'b1, 1'b0, 1'b0, tdo);
      tms_step(1'b0, 1'b0, 1'b0, tdo);
      tms_step(1'b0, 1'b0, 1'b0, tdo);
      repeat (5) tms_step(1'b1, 1'b0, 1'b0, tdo);
      tms_step(1'b0, 1'b0, 1'b0, tdo);
      check_bit("tms reset tlr flag", 1'b1, tlr_flag);
      // The instruction returns to IDCODE on the edge that leaves Test-Logic-Reset.
      tms_step(1'b0, 1'b0, 1'b0, tdo);
      check_instr("tms reset instruction", instr_idcode, dut0.cur_instr);
      scan_dr(32, {$random(seed), $random(seed)}, dout);
      check_word("tms reset idcode", `JTAG_IDCODE_VALUE, dout[31:0]);
   endtask

   task automatic test_bypass(input string name, input jtag_instr_e code, input int n);
      logic [`JTAG_IR_LEN-1:0] captured;
      logic [63:0]             din;
      logic [63:0]             dout;
      load_ir(code, captured);
      check_instr({name, " instruction"}, code, dut0.cur_instr);
      check_bit({name, " debug select"}, 1'b0, debug_sel);
      din = {$random(seed), $random(seed)};
      scan_dr(n, din, dout);
      // The bypass bit captures 0, then each TDI bit comes back one cycle later.
      check_bit({name, " bypass capture"}, 1'b0, dout[0]);
      for (int i = 1; i < n; i++)
      begin
         check_bit({name, " bypass delay"}, din[i-1], dout[i]);
      end
   endtask

   task automatic test_debug();
      logic [`JTAG_IR_LEN-1:0] captured;
      logic                    tdo;
      logic                    dbg;
      logic                    dbg_prev;
      load_ir(instr_debug, captured);
      check_instr("debug instruction", instr_debug, dut0.cur_instr);
      check_bit("debug select", 1'b1, debug_sel);
      dr_flag_step("debug idle", 1'b1, 3'b000, tdo, dbg);
      dr_flag_step("debug select-dr", 1'b0, 3'b000, tdo, dbg);
      dr_flag_step("debug capture-dr", 1'b0, 3'b100, tdo, dbg);
      // TDO shows the debug input as it stood on the previous falling edge.
      for (int i = 0; i < 24; i++)
      begin
         dbg_prev = dbg;
         dr_flag_step("debug shift-dr", i == 23, 3'b010, tdo, dbg);
         check_bit("debug tdo", dbg_prev, tdo);
      end
      dr_flag_step("debug exit1-dr", 1'b1, 3'b000, tdo, dbg);
      dr_flag_step("debug update-dr", 1'b0, 3'b001, tdo, dbg);
      dr_flag_step("debug idle after update", 1'b0, 3'b000, tdo, dbg);
      check_bit("debug select kept", 1'b1, debug_sel);
   endtask

   task automatic test_async_reset();
      logic [`JTAG_IR_LEN-1:0] captured;
      logic                    tdo;
      logic [63:0]             dout;
      // DEBUG is loaded first, so reset has a raised select and a non-reset code to clear.
      load_ir(instr_debug, captured);
      // TMS stays high through reset so the FSM remains in Test-Logic-Reset.
      tms_step(1'b1, 1'b0, 1'b0, tdo);
      clk0.apply_reset();
      check_bit("trst debug select", 1'b0, debug_sel);
      check_instr("trst instruction", instr_idcode, dut0.cur_instr);
      tms_step(1'b0, 1'b0, 1'b0, tdo);
      check_bit("trst tlr flag", 1'b1, tlr_flag);
      scan_dr(32, {$random(seed), $random(seed)}, dout);
      check_word("trst idcode", `JTAG_IDCODE_VALUE, dout[31:0]);
   endtask

   // Ends the run if the tests stall.
   always @(posedge jtag_tck)
   begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("Timeout: the tests did not finish within %0d TCK cycles", CYCLE_LIMIT);
         $display("Errors: %0d", errors);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   initial
   begin
      seed      = 32'hc7d4fb1e;
      jtag_tms  = 1'b1;
      jtag_tdi  = 1'b0;
      debug_tdo = 1'b0;
      @(posedge jtag_trstn);
      test_reset_idcode();
      test_ir_capture_tms_reset();
      test_bypass("bypass", instr_bypass, 40);
      test_debug();
      test_bypass("mbist", instr_mbist, 16);
      test_bypass("undefined code", jtag_instr_e'(4'b0101), 16);
      test_async_reset();
      $display("Errors: %0d", errors);
      if (errors == 0)
      begin
         $display("SIMULATION PASSED");
      end
      else
      begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- hdl/jtag_data_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "jtag_tap_macros.svh"

module jtag_data_regs
   import jtag_tap_state_pkg::*;
   import jtag_tap_instr_pkg::*;
(
   input  logic        jtag_tck_i,
   input  logic        jtag_trstn_i,
   input  logic        jtag_tdi_i,
   input  logic        debug_tdo_i,
   input  tap_flags_s  tap_flags_i,
   input  jtag_instr_e cur_instr_i,
   input  logic        ir_tdo_i,
   output logic        jtag_tdo_o
);

   logic [31:0] idcode_q;
   logic        bypass_q;

   // Data registers are loaded in Capture-DR before any shift.
   // Their contents before that are never shown in Shift-DR.
   // DEBUG has its register in the external chain, so nothing happens here.
   always_ff @(posedge jtag_tck_i)
   begin
      if (tap_flags_i.capture_dr)
      begin
         case (cur_instr_i)
            instr_idcode:
            begin
               idcode_q <= `JTAG_IDCODE_VALUE;
            end
            instr_debug:
            begin
            end
            default:
            begin
               // The standard requires BYPASS to capture 0.
               bypass_q <= 1'b0;
            end
         endcase
      end
      else if (tap_flags_i.shift_dr)
      begin
         case (cur_instr_i)
            instr_idcode:
            begin
               // Shifting overwrites the identifier until the next capture.
               idcode_q <= {jtag_tdi_i, idcode_q[31:1]};
            end
            instr_debug:
            begin
            end
            default:
            begin
               bypass_q <= jtag_tdi_i;
            end
         endcase
      end
   end

   // TDO changes on the falling edge so it is stable at the next rising edge.
   // In Shift-IR the instruction path drives it.
   // Otherwise the register chosen by the current instruction does.
   always_ff @(negedge jtag_tck_i or negedge jtag_trstn_i)
   begin
      if (!jtag_trstn_i)
      begin
         jtag_tdo_o <= 1'b0;
      end
      else if (tap_flags_i.shift_ir)
      begin
         jtag_tdo_o <= ir_tdo_i;
      end
      else
      begin
         case (cur_instr_i)
            instr_idcode: jtag_tdo_o <= idcode_q[0];
            instr_debug:  jtag_tdo_o <= debug_tdo_i;
            default:      jtag_tdo_o <= bypass_q;
         endcase
      end
   end

   // A capture always precedes Shift-DR, so the shifted bit is always known.
   a_tdo_known: assert property (
      @(posedge jtag_tck_i) disable iff (!jtag_trstn_i)
      tap_flags_i.shift_dr |-> !$isunknown(jtag_tdo_o)
   );

endmodule

`default_nettype wire

//--- hdl/jtag_instr_reg.sv
`timescale 1ns/100ps
`default_nettype none

`include "jtag_tap_macros.svh"

module jtag_instr_reg
   import jtag_tap_state_pkg::*;
   import jtag_tap_instr_pkg::*;
(
   input  logic        jtag_tck_i,
   input  logic        jtag_trstn_i,
   input  logic        jtag_tdi_i,
   input  tap_flags_s  tap_flags_i,
   output jtag_instr_e cur_instr_o,
   output logic        ir_tdo_o,
   output logic        is_tap_current_instruction_debug_o
);

   ir_word_u ir_word_q;

   // Shift register of the instruction path.
   // It is always loaded in Capture-IR before it is shifted, so it needs no reset.
   // TDI enters at the top and bit 0 leaves towards TDO.
   always_ff @(posedge jtag_tck_i)
   begin
      if (tap_flags_i.capture_ir)
      begin
         ir_word_q.capture.status <= `JTAG_IR_CAPTURE_STATUS;
         ir_word_q.capture.marker <= `JTAG_IR_CAPTURE_MARKER;
      end
      else if (tap_flags_i.shift_ir)
      begin
         ir_word_q <= {jtag_tdi_i, ir_word_q[`JTAG_IR_LEN-1:1]};
      end
   end

   assign ir_tdo_o = ir_word_q[0];

   // Current instruction, updated on the edge that leaves Update-IR.
   // IDCODE is the reset instruction since this device has one.
   always_ff @(posedge jtag_tck_i or negedge jtag_trstn_i)
   begin
      if (!jtag_trstn_i)
      begin
         cur_instr_o                        <= instr_idcode;
         is_tap_current_instruction_debug_o <= 1'b0;
      end
      else if (tap_flags_i.test_logic_reset)
      begin
         cur_instr_o                        <= instr_idcode;
         is_tap_current_instruction_debug_o <= 1'b0;
      end
      else if (tap_flags_i.update_ir)
      begin
         cur_instr_o                        <= ir_word_q.instr;
         is_tap_current_instruction_debug_o <= (ir_word_q.instr == instr_debug);
      end
   end

   // The capture in Capture-IR must leave the marker in the low bits.
   a_capture_marker: assert property (
      @(posedge jtag_tck_i) disable iff (!jtag_trstn_i)
      tap_flags_i.capture_ir |=> (ir_word_q.capture.marker == `JTAG_IR_CAPTURE_MARKER)
   );

endmodule

`default_nettype wire

//--- hdl/jtag_tap_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module jtag_tap_fsm
   import jtag_tap_state_pkg::*;
(
   input  logic       jtag_tck_i,
   input  logic       jtag_trstn_i,
   input  logic       jtag_tms_i,
   output tap_flags_s tap_flags_o
);

   tap_state_e state_q;
   tap_state_e state_nxt;
   tap_flags_s flags_nxt;

   // Full state table of the controller.
   // Every state has exactly two successors, picked by TMS.
   always_comb
   begin
      case (state_q)
         st_test_logic_reset: state_nxt = jtag_tms_i ? st_test_logic_reset : st_run_test_idle;
         st_run_test_idle:    state_nxt = jtag_tms_i ? st_select_dr_scan : st_run_test_idle;
         st_select_dr_scan:   state_nxt = jtag_tms_i ? st_select_ir_scan : st_capture_dr;
         st_capture_dr:       state_nxt = jtag_tms_i ? st_exit1_dr : st_shift_dr;
         st_shift_dr:         state_nxt = jtag_tms_i ? st_exit1_dr : st_shift_dr;
         st_exit1_dr:         state_nxt = jtag_tms_i ? st_update_dr : st_pause_dr;
         st_pause_dr:         state_nxt = jtag_tms_i ? st_exit2_dr : st_pause_dr;
         st_exit2_dr:         state_nxt = jtag_tms_i ? st_update_dr : st_shift_dr;
         st_update_dr:        state_nxt = jtag_tms_i ? st_select_dr_scan : st_run_test_idle;
         st_select_ir_scan:   state_nxt = jtag_tms_i ? st_test_logic_reset : st_capture_ir;
         st_capture_ir:       state_nxt = jtag_tms_i ? st_exit1_ir : st_shift_ir;
         st_shift_ir:         state_nxt = jtag_tms_i ? st_exit1_ir : st_shift_ir;
         st_exit1_ir:         state_nxt = jtag_tms_i ? st_update_ir : st_pause_ir;
         st_pause_ir:         state_nxt = jtag_tms_i ? st_exit2_ir : st_pause_ir;
         st_exit2_ir:         state_nxt = jtag_tms_i ? st_update_ir : st_shift_ir;
         st_update_ir:        state_nxt = jtag_tms_i ? st_select_dr_scan : st_run_test_idle;
         default:             state_nxt = st_test_logic_reset;
      endcase
   end

   // Flags are decoded from the next state.
   // Registered with the state, they line up with it cycle for cycle.
   // States without a flag leave every bit low.
   always_comb
   begin
      flags_nxt                  = '0;
      flags_nxt.test_logic_reset = (state_nxt == st_test_logic_reset);
      flags_nxt.capture_dr       = (state_nxt == st_capture_dr);
      flags_nxt.shift_dr         = (state_nxt == st_shift_dr);
      flags_nxt.update_dr        = (state_nxt == st_update_dr);
      flags_nxt.capture_ir       = (state_nxt == st_capture_ir);
      flags_nxt.shift_ir         = (state_nxt == st_shift_ir);
      flags_nxt.update_ir        = (state_nxt == st_update_ir);
   end

   // Reset puts the controller into Test-Logic-Reset.
   // The flags stay low until the first rising edge after reset, as the blocks
   // reading them are already in their reset values.
   always_ff @(posedge jtag_tck_i or negedge jtag_trstn_i)
   begin
      if (!jtag_trstn_i)
      begin
         state_q     <= st_test_logic_reset;
         tap_flags_o <= '0;
      end
      else
      begin
         state_q     <= state_nxt;
         tap_flags_o <= flags_nxt;
      end
   end

   // The register blocks rely on never seeing two actions at once.
   a_flags_onehot0: assert property (
      @(posedge jtag_tck_i) disable iff (!jtag_trstn_i)
      $onehot0(tap_flags_o)
   );

   // Five rising edges with TMS high reach Test-Logic-Reset from any state.
   a_tms_reset: assert property (
      @(posedge jtag_tck_i) disable iff (!jtag_trstn_i)
      jtag_tms_i [*5] |=> tap_flags_o.test_logic_reset
   );

endmodule

`default_nettype wire

//--- hdl/jtag_tap_instr_pkg.sv
`default_nettype none

`include "jtag_tap_macros.svh"

package jtag_tap_instr_pkg;

   // Named instruction codes.
   // The register may still hold an unnamed code, which then selects BYPASS.
   typedef enum logic [`JTAG_IR_LEN-1:0] {
      instr_extest         = `JTAG_INSTR_EXTEST,
      instr_sample_preload = `JTAG_INSTR_SAMPLE_PRELOAD,
      instr_idcode         = `JTAG_INSTR_IDCODE,
      instr_debug          = `JTAG_INSTR_DEBUG,
      instr_mbist          = `JTAG_INSTR_MBIST,
      instr_bypass         = `JTAG_INSTR_BYPASS
   } jtag_instr_e;

   // Word loaded into the instruction register in Capture-IR.
   // The marker sits in the low bits and leaves the chain first.
   typedef struct packed {
      logic [1:0] status;
      logic [1:0] marker;
   } ir_capture_s;

   // The instruction register holds one word with two readings.
   // Capture-IR writes it as a status word.
   // Update-IR reads it as an instruction code.
   typedef union packed {
      jtag_instr_e instr;
      ir_capture_s capture;
   } ir_word_u;

endpackage

`default_nettype wire

//--- hdl/jtag_tap_macros.svh
`ifndef JTAG_TAP_MACROS_SVH
`define JTAG_TAP_MACROS_SVH

// Length of the instruction register in bits.
`define JTAG_IR_LEN 4

// Identifier returned by the IDCODE register.
// Bit 0 is 1 as the standard demands, so a host can tell IDCODE from BYPASS.
`define JTAG_IDCODE_VALUE 32'h0a17_3c5d

// Status bits loaded above the marker in Capture-IR.
// There is no real status to report, so a fixed pattern helps debugging.
`define JTAG_IR_CAPTURE_STATUS 2'b01

// The two low bits loaded in Capture-IR must be 01 by the standard.
`define JTAG_IR_CAPTURE_MARKER 2'b01

// Instruction codes.
// EXTEST, SAMPLE/PRELOAD and MBIST have no register of their own here.
// They behave like BYPASS, as does every code not listed.
`define JTAG_INSTR_EXTEST         4'b0000
`define JTAG_INSTR_SAMPLE_PRELOAD 4'b0001
`define JTAG_INSTR_IDCODE         4'b0010
`define JTAG_INSTR_DEBUG          4'b1000
`define JTAG_INSTR_MBIST          4'b1001
`define JTAG_INSTR_BYPASS         4'b1111

`endif

//--- hdl/jtag_tap_state_pkg.sv
`default_nettype none

package jtag_tap_state_pkg;

   // The sixteen states of the IEEE 1149.1 TAP controller.
   // The encoding has no meaning of its own.
   typedef enum logic [3:0] {
      st_test_logic_reset = 4'd0,
      st_run_test_idle    = 4'd1,
      st_select_dr_scan   = 4'd2,
      st_capture_dr       = 4'd3,
      st_shift_dr         = 4'd4,
      st_exit1_dr         = 4'd5,
      st_pause_dr         = 4'd6,
      st_exit2_dr         = 4'd7,
      st_update_dr        = 4'd8,
      st_select_ir_scan   = 4'd9,
      st_capture_ir       = 4'd10,
      st_shift_ir         = 4'd11,
      st_exit1_ir         = 4'd12,
      st_pause_ir         = 4'd13,
      st_exit2_ir         = 4'd14,
      st_update_ir        = 4'd15
   } tap_state_e;

   // One-hot view of the states that the register blocks act on.
   // Each bit is high for exactly the cycles the controller spends in that state.
   typedef struct packed {
      logic test_logic_reset;
      logic capture_dr;
      logic shift_dr;
      logic update_dr;
      logic capture_ir;
      logic shift_ir;
      logic update_ir;
   } tap_flags_s;

endpackage

`default_nettype wire

//--- hdl/jtag_tap_top.sv
`timescale 1ns/100ps
`default_nettype none

module jtag_tap_top
   import jtag_tap_state_pkg::*;
   import jtag_tap_instr_pkg::*;
(
   input  logic jtag_tck_i,
   input  logic jtag_trstn_i,
   input  logic jtag_tms_i,
   input  logic jtag_tdi_i,
   input  logic debug_tdo_i,
   output logic jtag_tdo_o,
   output logic is_tap_state_test_logic_reset_o,
   output logic is_tap_state_capture_dr_o,
   output logic is_tap_state_shift_dr_o,
   output logic is_tap_state_update_dr_o,
   output logic is_tap_current_instruction_debug_o
);

   tap_flags_s  tap_flags;
   jtag_instr_e cur_instr;
   logic        ir_tdo;

   // TAP controller. Its flags steer both register blocks.
   jtag_tap_fsm u_fsm (
      .jtag_tck_i   (jtag_tck_i),
      .jtag_trstn_i (jtag_trstn_i),
      .jtag_tms_i   (jtag_tms_i),
      .tap_flags_o  (tap_flags)
   );

   // Instruction path with the current instruction and the debug select.
   jtag_instr_reg u_instr_reg (
      .jtag_tck_i                         (jtag_tck_i),
      .jtag_trstn_i                       (jtag_trstn_i),
      .jtag_tdi_i                         (jtag_tdi_i),
      .tap_flags_i                        (tap_flags),
      .cur_instr_o                        (cur_instr),
      .ir_tdo_o                           (ir_tdo),
      .is_tap_current_instruction_debug_o (is_tap_current_instruction_debug_o)
   );

   // IDCODE and BYPASS registers plus the TDO output stage.
   jtag_data_regs u_data_regs (
      .jtag_tck_i   (jtag_tck_i),
      .jtag_trstn_i (jtag_trstn_i),
      .jtag_tdi_i   (jtag_tdi_i),
      .debug_tdo_i  (debug_tdo_i),
      .tap_flags_i  (tap_flags),
      .cur_instr_i  (cur_instr),
      .ir_tdo_i     (ir_tdo),
      .jtag_tdo_o   (jtag_tdo_o)
   );

   // The debug chain follows the DR states and Test-Logic-Reset.
   assign is_tap_state_test_logic_reset_o = tap_flags.test_logic_reset;
   assign is_tap_state_capture_dr_o       = tap_flags.capture_dr;
   assign is_tap_state_shift_dr_o         = tap_flags.shift_dr;
   assign is_tap_state_update_dr_o        = tap_flags.update_dr;

endmodule

`default_nettype wire
